// ==== filelist.f ====
logic/rvCorePkg.sv
logic/instDecode.sv
logic/aluExecute.sv
logic/pcFetch.sv
logic/memResult.sv
logic/riscvTop.sv
tb/riscvTop_assertions.sv
tb/riscvTopTb.sv

// ==== Bender.yml ====
package:
  name: riscvTop

sources:
  - files:
      - logic/rvCorePkg.sv
      - logic/instDecode.sv
      - logic/aluExecute.sv
      - logic/pcFetch.sv
      - logic/memResult.sv
      - logic/riscvTop.sv
  - target: simulation
    files:
      - tb/riscvTop_assertions.sv
      - tb/riscvTopTb.sv

// ==== tb/riscvTopTb.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscvTopTb;

	localparam int progLen = 200;
	localparam int numPrograms = 8;
	localparam int cycleLimit = numPrograms * (progLen + 10);
	localparam rvCorePkg::word_t ebreakInst = 32'h00100073;

	logic                   CLK;
	logic                   RSTn;
	logic                   iMemCsn;
	rvCorePkg::word_t       iMemDi;
	rvCorePkg::memAddr_t    iMemAddr;
	logic                   dMemCsn;
	rvCorePkg::word_t       dMemDi;
	rvCorePkg::word_t       dMemDout;
	rvCorePkg::memAddr_t    dMemAddr;
	logic                   dMemWen;
	logic [3:0]             dMemBe;
	logic                   rfWe;
	rvCorePkg::regAddr_t    rfRa1;
	rvCorePkg::regAddr_t    rfRa2;
	rvCorePkg::regAddr_t    rfWa;
	rvCorePkg::word_t       rfRd1;
	rvCorePkg::word_t       rfRd2;
	rvCorePkg::word_t       rfWd;
	logic                   halt;
	rvCorePkg::word_t       numInst;
	rvCorePkg::word_t       outputPort;

	// What the ISA model expects from one instruction
	typedef struct packed {
		logic                readsRs1;
		logic                readsRs2;
		rvCorePkg::regAddr_t ra1;
		rvCorePkg::regAddr_t ra2;
		logic                we;
		rvCorePkg::regAddr_t wa;
		rvCorePkg::word_t    wd;
		logic                memWe;
		logic                memAcc;
		rvCorePkg::memAddr_t addr;
		logic [3:0]          be;
		rvCorePkg::word_t    data;  // Store data already in its lanes
		rvCorePkg::memAddr_t nextPc;
		logic                halt;
	} expect_t;

	rvCorePkg::word_t    imem [1024];
	rvCorePkg::word_t    dmem [1024];
	rvCorePkg::word_t    rf [32];
	rvCorePkg::word_t    mMem [1024];  // Model copies
	rvCorePkg::word_t    mRegs [32];
	rvCorePkg::memAddr_t mPc;
	rvCorePkg::word_t    mCount;
	logic                mHalted;
	expect_t             expected;
	int                  errorCount = 0;
	int                  checkCount = 0;
	int                  cycleCount = 0;

	riscvTop dut0 (.*);

	bind riscvTop riscvTopAssertions assert0 (
		.CLK      (CLK),
		.RSTn     (RSTn),
		.halt     (halt),
		.rfWe     (rfWe),
		.dMemWen  (dMemWen),
		.dMemBe   (dMemBe),
		.iMemAddr (iMemAddr),
		.numInst  (numInst)
	);

	always #50 CLK = ~CLK;

	// Memories and register file answer combinationally
	assign iMemDi = imem[iMemAddr[11:2]];
	assign dMemDi = dmem[dMemAddr[11:2]];
	assign rfRd1  = rf[rfRa1];
	assign rfRd2  = rf[rfRa2];

	always @(posedge CLK) begin
		if (rfWe && rfWa != 5'd0)
			rf[rfWa] <= rfWd;
		if (dMemWen)
			for (int b = 0; b < 4; b++)
				if (dMemBe[b])
					dmem[dMemAddr[11:2]][8*b +: 8] <= dMemDout[8*b +: 8];
	end

	always @(posedge CLK) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout after %0d cycles, the core never halted", cycleCount);
			printSummary();
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic rvCorePkg::word_t aluRef(input logic [2:0] f3, input logic alt,
			input rvCorePkg::word_t a, input rvCorePkg::word_t b);
		case (f3)
			3'd0: aluRef = alt ? a - b : a + b;
			3'd1: aluRef = a << b[4:0];
			3'd2: aluRef = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: aluRef = (a < b) ? 32'd1 : 32'd0;
			3'd4: aluRef = a ^ b;
			3'd5: begin
				if (alt)
					aluRef = $signed(a) >>> b[4:0];
				else
					aluRef = a >> b[4:0];
			end
			3'd6: aluRef = a | b;
			default: aluRef = a & b;
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] f3, input rvCorePkg::word_t a,
			input rvCorePkg::word_t b);
		case (f3)
			3'd0: branchTaken = (a == b);
			3'd1: branchTaken = (a != b);
			3'd4: branchTaken = ($signed(a) < $signed(b));
			3'd5: branchTaken = ($signed(a) >= $signed(b));
			3'd6: branchTaken = (a < b);
			3'd7: branchTaken = (a >= b);
			default: branchTaken = 1'b0;
		endcase
	endfunction

	// One ISA step from the model state, without committing it
	function automatic expect_t predict();
		expect_t e;
		rvCorePkg::word_t in;
		rvCorePkg::word_t a;
		rvCorePkg::word_t b;
		rvCorePkg::word_t immI;
		rvCorePkg::word_t sum;
		rvCorePkg::word_t word;
		in   = imem[mPc[11:2]];
		a    = mRegs[in[19:15]];
		b    = mRegs[in[24:20]];
		immI = {{20{in[31]}}, in[31:20]};
		e    = '0;
		e.ra1 = in[19:15];
		e.ra2 = in[24:20];
		e.readsRs1 = !(in[6:0] inside {rvCorePkg::OP_LUI, rvCorePkg::OP_AUIPC,
			rvCorePkg::OP_JAL, rvCorePkg::OP_SYSTEM});
		e.readsRs2 = in[6:0] inside {rvCorePkg::OP_BRANCH, rvCorePkg::OP_STORE,
			rvCorePkg::OP_OP};
		e.wa = in[11:7];
		e.nextPc = mPc + 12'd4;
		case (in[6:0])
			rvCorePkg::OP_LUI: begin
				e.we = 1'b1;
				e.wd = {in[31:12], 12'd0};
			end
			rvCorePkg::OP_AUIPC: begin
				e.we = 1'b1;
				e.wd = {20'd0, mPc} + {in[31:12], 12'd0};
			end
			rvCorePkg::OP_JAL: begin
				e.we = 1'b1;
				e.wd = {20'd0, mPc + 12'd4};
				e.nextPc = mPc + {in[31], in[19:12], in[20], in[30:21], 1'b0};
			end
			rvCorePkg::OP_JALR: begin
				e.we = 1'b1;
				e.wd = {20'd0, mPc + 12'd4};
				sum = a + immI;
				e.nextPc = {sum[11:1], 1'b0};
			end
			rvCorePkg::OP_BRANCH:
				if (branchTaken(in[14:12], a, b))
					e.nextPc = mPc + {in[7], in[30:25], in[11:8], 1'b0};
			rvCorePkg::OP_LOAD: begin
				e.we = 1'b1;
				e.memAcc = 1'b1;
				sum = a + immI;
				e.addr = sum[11:0];
				word = mMem[e.addr[11:2]] >> (8 * e.addr[1:0]);
				case (in[14:12])
					3'd0: e.wd = {{24{word[7]}}, word[7:0]};
					3'd1: e.wd = {{16{word[15]}}, word[15:0]};
					3'd4: e.wd = {24'd0, word[7:0]};
					3'd5: e.wd = {16'd0, word[15:0]};
					default: e.wd = word;
				endcase
			end
			rvCorePkg::OP_STORE: begin
				e.memWe = 1'b1;
				e.memAcc = 1'b1;
				sum = a + {{20{in[31]}}, in[31:25], in[11:7]};
				e.addr = sum[11:0];
				e.data = b << (8 * e.addr[1:0]);
				case (in[13:12])
					2'd0: e.be = 4'b0001 << e.addr[1:0];
					2'd1: e.be = 4'b0011 << e.addr[1:0];
					default: e.be = 4'b1111;
				endcase
			end
			rvCorePkg::OP_OPIMM: begin
				e.we = 1'b1;
				e.wd = aluRef(in[14:12], in[30] & (in[14:12] == 3'd5), a, immI);
			end
			rvCorePkg::OP_OP: begin
				e.we = 1'b1;
				e.wd = aluRef(in[14:12], in[30], a, b);
			end
			rvCorePkg::OP_SYSTEM: e.halt = 1'b1;
			default: ;
		endcase
		if (e.wa == 5'd0)
			e.we = 1'b0;
		return e;
	endfunction

	task automatic logMismatch(input string name, input rvCorePkg::word_t got,
			input rvCorePkg::word_t want);
		$display("mismatch %s at pc %h: got %h, expected %h", name, mPc, got, want);
		errorCount++;
	endtask

	task automatic failCheck(input string what);
		$display("error at pc %h: %s", mPc, what);
		errorCount++;
	endtask

	task automatic printSummary();
		$display("%0d checks done, %0d errors", checkCount, errorCount);
	endtask

	// Random program with forward-only control flow, ending in EBREAK
	task automatic loadProgram();
		rvCorePkg::word_t val;
		rvCorePkg::word_t inst;
		rvCorePkg::word_t off;
		rvCorePkg::regAddr_t rd;
		rvCorePkg::regAddr_t rs1;
		rvCorePkg::regAddr_t rs2;
		rvCorePkg::regAddr_t base;
		logic [2:0] f3;
		int kind;
		int fwd;
		int imm;
		for (int r = 0; r < 32; r++) begin
			// x1 to x4 hold aligned bases and are never written
			val = (r == 0) ? 32'd0 : (r <= 4) ? $urandom_range(0, 255) * 4 : $urandom;
			rf[r] <= val;
			mRegs[r] = val;
		end
		for (int w = 0; w < 1024; w++) begin
			val = $urandom;
			dmem[w] <= val;
			mMem[w] = val;
		end
		for (int i = 0; i < progLen; i++) begin
			kind = $urandom_range(0, 10);
			val  = $urandom;
			rd   = ($urandom_range(0, 15) == 0) ? 5'd0 : 5'($urandom_range(5, 31));
			rs1  = 5'($urandom_range(0, 31));
			rs2  = 5'($urandom_range(0, 31));
			base = 5'($urandom_range(1, 4));
			f3   = 3'($urandom_range(0, 7));
			fwd  = 4 * $urandom_range(1, (progLen - i < 8) ? progLen - i : 8);
			imm  = $urandom_range(0, 1023) - 512;
			case (kind)
				0: inst = {val[31:12], rd, rvCorePkg::OP_LUI};
				1: inst = {val[31:12], rd, rvCorePkg::OP_AUIPC};
				2: begin
					off  = fwd;
					inst = {off[20], off[10:1], off[11], off[19:12], rd, rvCorePkg::OP_JAL};
				end
				3: begin
					off  = i * 4 + fwd - mRegs[base] + val[0];  // Odd offset now and then
					inst = {off[11:0], base, 3'd0, rd, rvCorePkg::OP_JALR};
				end
				4: begin
					f3 = 3'($urandom_range(0, 5));
					if (f3 >= 3'd2)
						f3 = f3 + 3'd2;
					off  = fwd;
					inst = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11],
						rvCorePkg::OP_BRANCH};
				end
				5: begin
					f3 = 3'($urandom_range(0, 4));
					if (f3 >= 3'd3)
						f3 = f3 + 3'd1;
					off  = (imm >>> f3[1:0]) <<< f3[1:0];  // Aligned to access size
					inst = {off[11:0], base, f3, rd, rvCorePkg::OP_LOAD};
				end
				6: begin
					f3   = 3'($urandom_range(0, 2));
					off  = (imm >>> f3[1:0]) <<< f3[1:0];
					inst = {off[11:5], rs2, base, f3, off[4:0], rvCorePkg::OP_STORE};
				end
				7, 8: begin
					off = val;
					if (f3 == 3'd1)
						off[11:5] = 7'd0;
					if (f3 == 3'd5)
						off[11:5] = {1'b0, val[30], 5'd0};
					inst = {off[11:0], rs1, f3, rd, rvCorePkg::OP_OPIMM};
				end
				default:
					inst = {1'b0, (f3 == 3'd0 || f3 == 3'd5) & val[30], 5'd0, rs2, rs1, f3, rd,
						rvCorePkg::OP_OP};
			endcase
			imem[i] = inst;
		end
		imem[progLen] = ebreakInst;
		mPc     = '0;
		mCount  = '0;
		mHalted = 1'b0;
	endtask

	task automatic commitModel();
		if (expected.we)
			mRegs[expected.wa] = expected.wd;
		if (expected.memWe)
			for (int b = 0; b < 4; b++)
				if (expected.be[b])
					mMem[expected.addr[11:2]][8*b +: 8] = expected.data[8*b +: 8];
		mPc = expected.nextPc;
		mCount = mCount + 32'd1;
		if (expected.halt)
			mHalted = 1'b1;
	endtask

	task automatic checkInstruction();
		rvCorePkg::word_t mask;
		expected = predict();
		mask = {{8{expected.be[3]}}, {8{expected.be[2]}},
			{8{expected.be[1]}}, {8{expected.be[0]}}};
		checkCount++;
		if (iMemAddr !== mPc)
			logMismatch("iMemAddr", iMemAddr, mPc);
		if (iMemCsn !== 1'b0 || dMemCsn !== 1'b0)
			failCheck("a chip select is high while the core runs");
		if (expected.readsRs1 && rfRa1 !== expected.ra1)
			logMismatch("rfRa1", rfRa1, expected.ra1);
		if (expected.readsRs2 && rfRa2 !== expected.ra2)
			logMismatch("rfRa2", rfRa2, expected.ra2);
		if (rfWe !== expected.we)
			logMismatch("rfWe", rfWe, expected.we);
		if (expected.we && rfWa !== expected.wa)
			logMismatch("rfWa", rfWa, expected.wa);
		if (expected.we && rfWd !== expected.wd)
			logMismatch("rfWd", rfWd, expected.wd);
		if (expected.we && outputPort !== expected.wd)
			logMismatch("outputPort", outputPort, expected.wd);
		if (dMemWen !== expected.memWe)
			logMismatch("dMemWen", dMemWen, expected.memWe);
		if (expected.memAcc && dMemAddr !== expected.addr)
			logMismatch("dMemAddr", dMemAddr, expected.addr);
		if (expected.memWe && dMemBe !== expected.be)
			logMismatch("dMemBe", dMemBe, expected.be);
		if (expected.memWe && (dMemDout & mask) !== (expected.data & mask))
			logMismatch("dMemDout", dMemDout & mask, expected.data & mask);
		commitModel();
	endtask

	task automatic checkReset();
		checkCount++;
		if (rfWe !== 1'b0 || dMemWen !== 1'b0)
			failCheck("a write enable is high during reset");
		if (iMemCsn !== 1'b1 || dMemCsn !== 1'b1)
			failCheck("a chip select is low during reset");
		if (iMemAddr !== 12'd0)
			logMismatch("iMemAddr", iMemAddr, 32'd0);
		if (halt !== 1'b0)
			failCheck("halt is set during reset");
	endtask

	task automatic checkHalted();
		checkCount++;
		if (halt !== 1'b1)
			failCheck("halt is not set after EBREAK");
		if (numInst !== mCount)
			logMismatch("numInst", numInst, mCount);
		if (rfWe !== 1'b0 || dMemWen !== 1'b0)
			failCheck("a write enable is high after halt");
		if (iMemCsn !== 1'b1 || dMemCsn !== 1'b1)
			failCheck("a chip select is low after halt");
	endtask

	task automatic compareState();
		for (int w = 0; w < 1024; w++)
			if (dmem[w] !== mMem[w])
				logMismatch($sformatf("dmem[%h]", w * 4), dmem[w], mMem[w]);
		for (int r = 1; r < 32; r++)
			if (rf[r] !== mRegs[r])
				logMismatch($sformatf("x%0d", r), rf[r], mRegs[r]);
	endtask

	// Checks sample a quarter cycle after the falling edge
	task automatic runProgram();
		@(negedge CLK);
		RSTn = 1'b1;
		loadProgram();
		repeat (3) begin
			@(negedge CLK);
			#25;
			checkReset();
		end
		@(negedge CLK);
		RSTn = 1'b0;
		while (!mHalted) begin
			#25;
			checkInstruction();
			@(negedge CLK);
		end
		repeat (2) begin
			#25;
			checkHalted();
			@(negedge CLK);
		end
		compareState();
	endtask

	initial begin
		void'($urandom(6));
		CLK  = 1'b0;
		RSTn = 1'b1;
		for (int a = progLen + 1; a < 1024; a++)
			imem[a] = ebreakInst;
		for (int p = 0; p < numPrograms; p++)
			runProgram();
		errorCount += dut0.assert0.failCount;  // Bound checker failures
		printSummary();
		if (errorCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/riscvTop_assertions.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscvTopAssertions (
	input wire logic                CLK,
	input wire logic                RSTn,
	input wire logic                halt,
	input wire logic                rfWe,
	input wire logic                dMemWen,
	input wire logic [3:0]          dMemBe,
	input wire rvCorePkg::memAddr_t iMemAddr,
	input wire rvCorePkg::word_t    numInst
);

	int failCount = 0;  // Failed assertions so far

	noWriteWhenHalted: assert property (@(posedge CLK) disable iff (RSTn)
		halt |-> !rfWe && !dMemWen)
		else begin
			failCount++;
			$error("write enable high while halted");
		end

	byteEnableOnWrite: assert property (@(posedge CLK) disable iff (RSTn)
		dMemWen |-> dMemBe != 4'b0000)
		else begin
			failCount++;
			$error("data memory write with no byte enabled");
		end

	fetchAligned: assert property (@(posedge CLK) disable iff (RSTn) iMemAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("instruction address not word aligned");
		end

	// Counter frozen once halted
	countFrozen: assert property (@(posedge CLK) disable iff (RSTn) halt |=> $stable(numInst))
		else begin
			failCount++;
			$error("numInst changed while halted");
		end

endmodule

`default_nettype wire

// ==== logic/riscvTop.sv ====
`timescale 1ns/100ps
`default_nettype none

module riscvTop (
	input  wire logic                CLK,
	input  wire logic                RSTn,

	output logic                     iMemCsn,
	input  wire rvCorePkg::word_t    iMemDi,
	output rvCorePkg::memAddr_t      iMemAddr,   // Byte address

	output logic                     dMemCsn,
	input  wire rvCorePkg::word_t    dMemDi,
	output rvCorePkg::word_t         dMemDout,
	output rvCorePkg::memAddr_t      dMemAddr,
	output logic                     dMemWen,
	output logic [3:0]               dMemBe,

	output logic                     rfWe,
	output rvCorePkg::regAddr_t      rfRa1,
	output rvCorePkg::regAddr_t      rfRa2,
	output rvCorePkg::regAddr_t      rfWa,
	input  wire rvCorePkg::word_t    rfRd1,
	input  wire rvCorePkg::word_t    rfRd2,
	output rvCorePkg::word_t         rfWd,
	output logic                     halt,
	output rvCorePkg::word_t         numInst,
	output rvCorePkg::word_t         outputPort  // Mirrors rfWd
);

	rvCorePkg::decodeCtrl_t ctrl;
	rvCorePkg::exeResult_t  res;
	rvCorePkg::word_t       imm;
	rvCorePkg::memAddr_t    pc;
	rvCorePkg::memAddr_t    pcPlus4;
	logic                   memWen;
	logic                   running;

	instDecode decode0 (
		.inst (iMemDi),
		.rs1  (rfRa1),
		.rs2  (rfRa2),
		.rd   (rfWa),
		.imm  (imm),
		.ctrl (ctrl)
	);

	aluExecute exe0 (
		.ctrl (ctrl),
		.pc   (pc),
		.rd1  (rfRd1),
		.rd2  (rfRd2),
		.imm  (imm),
		.res  (res)
	);

	pcFetch pc0 (
		.CLK     (CLK),
		.RSTn    (RSTn),
		.ctrl    (ctrl),
		.res     (res),
		.pc      (pc),
		.pcPlus4 (pcPlus4),
		.halt    (halt),
		.numInst (numInst),
		.iMemCsn (iMemCsn)
	);

	memResult res0 (
		.ctrl     (ctrl),
		.res      (res),
		.rd2      (rfRd2),
		.pcPlus4  (pcPlus4),
		.imm      (imm),
		.dMemDi   (dMemDi),
		.dMemAddr (dMemAddr),
		.dMemDout (dMemDout),
		.dMemBe   (dMemBe),
		.dMemWen  (memWen),
		.wbData   (rfWd)
	);

	// No writes in reset or after EBREAK
	assign running    = ~RSTn & ~halt;
	assign rfWe       = ctrl.regWrite & running;
	assign dMemWen    = memWen & running;
	assign dMemCsn    = ~running;
	assign iMemAddr   = pc;
	assign outputPort = rfWd;

endmodule

`default_nettype wire

// ==== logic/memResult.sv ====
`timescale 1ns/100ps
`default_nettype none

module memResult (
	input  wire rvCorePkg::decodeCtrl_t ctrl,
	input  wire rvCorePkg::exeResult_t  res,
	input  wire rvCorePkg::word_t       rd2,
	input  wire rvCorePkg::memAddr_t    pcPlus4,
	input  wire rvCorePkg::word_t       imm,
	input  wire rvCorePkg::word_t       dMemDi,
	output rvCorePkg::memAddr_t         dMemAddr,
	output rvCorePkg::word_t            dMemDout,
	output logic [3:0]                  dMemBe,
	output logic                        dMemWen,
	output rvCorePkg::word_t            wbData
);

	logic [1:0] byteOff;
	logic [3:0] laneMask;
	rvCorePkg::word_t shifted;
	rvCorePkg::word_t loadVal;

	assign dMemAddr = res.aluOut[11:0];
	assign byteOff  = res.aluOut[1:0];
	assign dMemWen  = ctrl.memWrite;

	// Store data goes out on every lane, byte enables pick the right ones
	always_comb begin
		case (ctrl.memSize)
			rvCorePkg::MEM_BYTE: begin
				dMemDout = {4{rd2[7:0]}};
				laneMask = 4'b0001 << byteOff;
			end
			rvCorePkg::MEM_HALF: begin
				dMemDout = {2{rd2[15:0]}};
				laneMask = byteOff[1] ? 4'b1100 : 4'b0011;
			end
			default: begin
				dMemDout = rd2;
				laneMask = 4'b1111;
			end
		endcase
	end

	assign dMemBe = (ctrl.memRead | ctrl.memWrite) ? laneMask : 4'b0000;

	assign shifted = dMemDi >> {byteOff, 3'b000};

	always_comb begin
		case (ctrl.memSize)
			rvCorePkg::MEM_BYTE:
				loadVal = ctrl.loadUnsigned ? {24'd0, shifted[7:0]}
					: {{24{shifted[7]}}, shifted[7:0]};
			rvCorePkg::MEM_HALF:
				loadVal = ctrl.loadUnsigned ? {16'd0, shifted[15:0]}
					: {{16{shifted[15]}}, shifted[15:0]};
			default:             loadVal = dMemDi;
		endcase
	end

	always_comb begin
		case (ctrl.wbSel)
			rvCorePkg::WB_MEM: wbData = loadVal;
			rvCorePkg::WB_PC4: wbData = {20'd0, pcPlus4};  // Link address
			rvCorePkg::WB_IMM: wbData = imm;
			default:           wbData = res.aluOut;
		endcase
	end

endmodule

`default_nettype wire

// ==== logic/pcFetch.sv ====
`timescale 1ns/100ps
`default_nettype none

module pcFetch (
	input  wire logic                   CLK,
	input  wire logic                   RSTn,
	input  wire rvCorePkg::decodeCtrl_t ctrl,
	input  wire rvCorePkg::exeResult_t  res,
	output rvCorePkg::memAddr_t         pc,
	output rvCorePkg::memAddr_t         pcPlus4,
	output logic                        halt,
	output rvCorePkg::word_t            numInst,
	output logic                        iMemCsn
);

	rvCorePkg::memAddr_t nextPc;

	assign pcPlus4 = pc + 12'd4;
	assign nextPc  = res.taken ? res.target : pcPlus4;

	// Deselect during reset and once halted
	assign iMemCsn = RSTn | halt;

	always_ff @(posedge CLK) begin
		if (RSTn) begin
			pc      <= '0;
			numInst <= '0;
			halt    <= 1'b0;
		end else if (!halt) begin
			pc      <= nextPc;
			numInst <= numInst + 32'd1;  // EBREAK counts too
			halt    <= ctrl.isHalt;
		end
	end

endmodule

`default_nettype wire

// ==== logic/aluExecute.sv ====
`timescale 1ns/100ps
`default_nettype none

module aluExecute (
	input  wire rvCorePkg::decodeCtrl_t ctrl,
	input  wire rvCorePkg::memAddr_t    pc,
	input  wire rvCorePkg::word_t       rd1,
	input  wire rvCorePkg::word_t       rd2,
	input  wire rvCorePkg::word_t       imm,
	output rvCorePkg::exeResult_t       res
);

	rvCorePkg::word_t   opA;
	rvCorePkg::word_t   opB;
	rvCorePkg::word_t   aluOut;
	rvCorePkg::memAddr_t target;
	logic [4:0] shamt;
	logic       condMet;

	assign opA   = ctrl.usePc ? {20'd0, pc} : rd1;
	assign opB   = ctrl.useImm ? imm : rd2;
	assign shamt = opB[4:0];

	always_comb begin
		case (ctrl.aluOp)
			rvCorePkg::ALU_ADD:   aluOut = opA + opB;
			rvCorePkg::ALU_SUB:   aluOut = opA - opB;
			rvCorePkg::ALU_SLL:   aluOut = opA << shamt;
			rvCorePkg::ALU_SLT:   aluOut = {31'd0, $signed(opA) < $signed(opB)};
			rvCorePkg::ALU_SLTU:  aluOut = {31'd0, opA < opB};
			rvCorePkg::ALU_XOR:   aluOut = opA ^ opB;
			rvCorePkg::ALU_SRL:   aluOut = opA >> shamt;
			rvCorePkg::ALU_SRA:   aluOut = $signed(opA) >>> shamt;
			rvCorePkg::ALU_OR:    aluOut = opA | opB;
			rvCorePkg::ALU_AND:   aluOut = opA & opB;
			rvCorePkg::ALU_PASSB: aluOut = opB;
			default:              aluOut = opA + opB;
		endcase
	end

	// Branch compare on register values, independent of operand muxes
	always_comb begin
		case (ctrl.funct3)
			3'b000:  condMet = (rd1 == rd2);
			3'b001:  condMet = (rd1 != rd2);
			3'b100:  condMet = ($signed(rd1) < $signed(rd2));
			3'b101:  condMet = ($signed(rd1) >= $signed(rd2));
			3'b110:  condMet = (rd1 < rd2);
			3'b111:  condMet = (rd1 >= rd2);
			default: condMet = 1'b0;
		endcase
	end

	// JALR takes rs1 + imm from the ALU, low bit cleared
	assign target = ctrl.isJalr ? {aluOut[11:1], 1'b0} : pc + imm[11:0];

	assign res.aluOut = aluOut;
	assign res.taken  = ctrl.isJal | ctrl.isJalr | (ctrl.isBranch & condMet);
	assign res.target = target;

endmodule

`default_nettype wire

// ==== logic/instDecode.sv ====
`timescale 1ns/100ps
`default_nettype none

module instDecode (
	input  wire rvCorePkg::word_t    inst,
	output rvCorePkg::regAddr_t      rs1,
	output rvCorePkg::regAddr_t      rs2,
	output rvCorePkg::regAddr_t      rd,
	output rvCorePkg::word_t         imm,
	output rvCorePkg::decodeCtrl_t   ctrl
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic       sgn;
	rvCorePkg::decodeCtrl_t c;

	// Register-immediate and register-register share the funct3 map
	function automatic rvCorePkg::aluOp_t aluFromFunct(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  aluFromFunct = alt ? rvCorePkg::ALU_SUB : rvCorePkg::ALU_ADD;
			3'b001:  aluFromFunct = rvCorePkg::ALU_SLL;
			3'b010:  aluFromFunct = rvCorePkg::ALU_SLT;
			3'b011:  aluFromFunct = rvCorePkg::ALU_SLTU;
			3'b100:  aluFromFunct = rvCorePkg::ALU_XOR;
			3'b101:  aluFromFunct = alt ? rvCorePkg::ALU_SRA : rvCorePkg::ALU_SRL;
			3'b110:  aluFromFunct = rvCorePkg::ALU_OR;
			default: aluFromFunct = rvCorePkg::ALU_AND;
		endcase
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign sgn    = inst[31];
	assign rs1    = inst[19:15];
	assign rs2    = inst[24:20];
	assign rd     = inst[11:7];

	always_comb begin
		case (opcode)
			rvCorePkg::OP_STORE:  imm = {{20{sgn}}, inst[31:25], inst[11:7]};
			rvCorePkg::OP_BRANCH: imm = {{19{sgn}}, sgn, inst[7], inst[30:25], inst[11:8], 1'b0};
			rvCorePkg::OP_LUI,
			rvCorePkg::OP_AUIPC:  imm = {inst[31:12], 12'd0};
			rvCorePkg::OP_JAL:    imm = {{11{sgn}}, sgn, inst[19:12], inst[20], inst[30:21], 1'b0};
			default:              imm = {{20{sgn}}, inst[31:20]};  // I-type
		endcase
	end

	always_comb begin
		c = '0;  // Unknown opcode ends up a no-op
		c.aluOp  = rvCorePkg::ALU_ADD;
		c.wbSel  = rvCorePkg::WB_ALU;
		c.funct3 = funct3;
		c.memSize = funct3[1:0];
		c.loadUnsigned = funct3[2];
		case (opcode)
			rvCorePkg::OP_LUI: begin
				c.regWrite = 1'b1;
				c.useImm   = 1'b1;
				c.aluOp    = rvCorePkg::ALU_PASSB;
				c.wbSel    = rvCorePkg::WB_IMM;
			end
			rvCorePkg::OP_AUIPC: begin
				c.regWrite = 1'b1;
				c.useImm   = 1'b1;
				c.usePc    = 1'b1;
			end
			rvCorePkg::OP_JAL: begin
				c.regWrite = 1'b1;
				c.isJal    = 1'b1;
				c.wbSel    = rvCorePkg::WB_PC4;
			end
			rvCorePkg::OP_JALR: begin
				c.regWrite = 1'b1;
				c.isJalr   = 1'b1;
				c.useImm   = 1'b1;
				c.wbSel    = rvCorePkg::WB_PC4;
			end
			rvCorePkg::OP_BRANCH: c.isBranch = 1'b1;
			rvCorePkg::OP_LOAD: begin
				c.regWrite = 1'b1;
				c.memRead  = 1'b1;
				c.useImm   = 1'b1;
				c.wbSel    = rvCorePkg::WB_MEM;
			end
			rvCorePkg::OP_STORE: begin
				c.memWrite = 1'b1;
				c.useImm   = 1'b1;
			end
			rvCorePkg::OP_OPIMM: begin
				c.regWrite = 1'b1;
				c.useImm   = 1'b1;
				// inst[30] only selects SRAI, ADDI has no SUB form
				c.aluOp    = aluFromFunct(funct3, inst[30] & (funct3 == 3'b101));
			end
			rvCorePkg::OP_OP: begin
				c.regWrite = 1'b1;
				c.aluOp    = aluFromFunct(funct3, inst[30]);
			end
			rvCorePkg::OP_SYSTEM: c.isHalt = (inst[31:7] == 25'h0002000);  // EBREAK
			default: ;
		endcase
		if (rd == 5'd0)
			c.regWrite = 1'b0;
	end

	assign ctrl = c;

endmodule

`default_nettype wire

// ==== logic/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0]  regAddr_t;
	typedef logic [11:0] memAddr_t;
	typedef logic [3:0]  aluOp_t;
	typedef logic [1:0]  wbSel_t;

	localparam aluOp_t ALU_ADD   = 4'd0;
	localparam aluOp_t ALU_SUB   = 4'd1;
	localparam aluOp_t ALU_SLL   = 4'd2;
	localparam aluOp_t ALU_SLT   = 4'd3;
	localparam aluOp_t ALU_SLTU  = 4'd4;
	localparam aluOp_t ALU_XOR   = 4'd5;
	localparam aluOp_t ALU_SRL   = 4'd6;
	localparam aluOp_t ALU_SRA   = 4'd7;
	localparam aluOp_t ALU_OR    = 4'd8;
	localparam aluOp_t ALU_AND   = 4'd9;
	localparam aluOp_t ALU_PASSB = 4'd10;

	// Major opcodes, inst[6:0]
	localparam logic [6:0] OP_LUI    = 7'b0110111;
	localparam logic [6:0] OP_AUIPC  = 7'b0010111;
	localparam logic [6:0] OP_JAL    = 7'b1101111;
	localparam logic [6:0] OP_JALR   = 7'b1100111;
	localparam logic [6:0] OP_BRANCH = 7'b1100011;
	localparam logic [6:0] OP_LOAD   = 7'b0000011;
	localparam logic [6:0] OP_STORE  = 7'b0100011;
	localparam logic [6:0] OP_OPIMM  = 7'b0010011;
	localparam logic [6:0] OP_OP     = 7'b0110011;
	localparam logic [6:0] OP_SYSTEM = 7'b1110011;

	localparam wbSel_t WB_ALU = 2'd0;
	localparam wbSel_t WB_MEM = 2'd1;
	localparam wbSel_t WB_PC4 = 2'd2;
	localparam wbSel_t WB_IMM = 2'd3;

	// Same encoding as funct3[1:0] of loads and stores
	localparam logic [1:0] MEM_BYTE = 2'd0;
	localparam logic [1:0] MEM_HALF = 2'd1;
	localparam logic [1:0] MEM_WORD = 2'd2;

	typedef struct packed {
		aluOp_t     aluOp;
		logic       useImm;  // B from immediate
		logic       usePc;   // A from PC
		logic       regWrite;
		logic       memRead;
		logic       memWrite;
		logic [1:0] memSize;
		logic       loadUnsigned;
		logic       isBranch;
		logic [2:0] funct3;
		logic       isJal;
		logic       isJalr;
		wbSel_t     wbSel;
		logic       isHalt;
	} decodeCtrl_t;

	typedef struct packed {
		word_t    aluOut;
		logic     taken;
		memAddr_t target;
	} exeResult_t;

endpackage

`default_nettype wire
